// ==== Makefile ====
TOP = cluster_bus_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f src.f
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== source/bus_addr_map.sv ====
// cluster address decoder
module bus_addr_map (
  input  logic [5:0]                                  cluster_id_i,
  input  logic [cluster_bus_pkg::NB_INITIATORS-1:0]   req_valid_i,
  input  logic [cluster_bus_pkg::NB_INITIATORS-1:0]
               [cluster_bus_pkg::ADDR_WIDTH-1:0]      req_addr_i,
  output logic [cluster_bus_pkg::NB_INITIATORS-1:0]   req_ready_o,
  output cluster_bus_pkg::tgt_idx_t
               [cluster_bus_pkg::NB_INITIATORS-1:0]   tgt_idx_o,
  // target-major, so each arbiter takes one row
  output logic [cluster_bus_pkg::NB_TARGETS-1:0]
               [cluster_bus_pkg::NB_INITIATORS-1:0]   tgt_valid_o,
  input  logic [cluster_bus_pkg::NB_TARGETS-1:0]
               [cluster_bus_pkg::NB_INITIATORS-1:0]   tgt_ready_i
);

  import cluster_bus_pkg::*;

  logic [ADDR_WIDTH-1:0]                     cluster_base;
  logic [NB_INITIATORS-1:0][ADDR_WIDTH-1:0]  offset;

  assign cluster_base = CLUSTER_BASE + (ADDR_WIDTH'(cluster_id_i) << CLUSTER_SHIFT);

  always_comb begin
    for (int i = 0; i < NB_INITIATORS; i++) begin
      // addresses below the base wrap to a large offset and fall through to ext
      offset[i] = req_addr_i[i] - cluster_base;

      if (offset[i] < TCDM_SIZE) begin
        tgt_idx_o[i] = TGT_TCDM;
      end else if (offset[i] >= PERIPH_OFFSET && offset[i] < CLUSTER_SIZE) begin
        tgt_idx_o[i] = TGT_PERIPH;
      end else begin
        // the 1 MiB to 2 MiB hole lands here too
        tgt_idx_o[i] = TGT_EXT;
      end

      for (int t = 0; t < NB_TARGETS; t++) begin
        tgt_valid_o[t][i] = req_valid_i[i] && (tgt_idx_o[i] == tgt_idx_t'(t));
      end
    end
  end

  // only the selected arbiter can grant this initiator
  always_comb begin
    for (int i = 0; i < NB_INITIATORS; i++) begin
      req_ready_o[i] = tgt_ready_i[tgt_idx_o[i]][i];
    end
  end

endmodule

// ==== source/bus_resp_route.sv ====
// response router back to the initiators
module bus_resp_route (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  // target side
  input  logic [cluster_bus_pkg::NB_TARGETS-1:0]     tgt_valid_i,
  output logic [cluster_bus_pkg::NB_TARGETS-1:0]     tgt_ready_o,
  input  logic [cluster_bus_pkg::NB_TARGETS-1:0]
               [cluster_bus_pkg::DATA_WIDTH-1:0]     tgt_rdata_i,
  input  logic [cluster_bus_pkg::NB_TARGETS-1:0]
               [cluster_bus_pkg::ID_OUT_WIDTH-1:0]   tgt_id_i,
  // initiator side
  output logic [cluster_bus_pkg::NB_INITIATORS-1:0]  rsp_valid_o,
  input  logic [cluster_bus_pkg::NB_INITIATORS-1:0]  rsp_ready_i,
  output logic [cluster_bus_pkg::NB_INITIATORS-1:0]
               [cluster_bus_pkg::DATA_WIDTH-1:0]     rsp_rdata_o,
  output logic [cluster_bus_pkg::NB_INITIATORS-1:0]
               [cluster_bus_pkg::ID_IN_WIDTH-1:0]    rsp_id_o
);

  import cluster_bus_pkg::*;

  // per-initiator selection, gathered for the target ready
  logic     [NB_INITIATORS-1:0] sel_found;
  tgt_idx_t [NB_INITIATORS-1:0] sel_idx;
  logic     [NB_INITIATORS-1:0] cut_ready;

  for (genvar i = 0; i < NB_INITIATORS; i++) begin : gen_init
    logic [NB_TARGETS-1:0] match;
    tgt_idx_t              rr_q;
    tgt_idx_t              pick;
    logic                  found;
    rsp_payload_t          cut_in;
    rsp_payload_t          cut_out;

    // a target response belongs here when its upper id bits name this initiator
    for (genvar t = 0; t < NB_TARGETS; t++) begin : gen_match
      assign match[t] = tgt_valid_i[t] &&
                        (tgt_id_i[t][ID_OUT_WIDTH-1 -: INIT_IDX_WIDTH] == INIT_IDX_WIDTH'(i));
    end

    // round robin over three targets, wrap by hand
    always_comb begin
      tgt_idx_t cand;
      found = 1'b0;
      pick  = rr_q;
      cand  = rr_q;
      for (int k = 0; k < NB_TARGETS; k++) begin
        cand = (cand == tgt_idx_t'(NB_TARGETS - 1)) ? '0 : cand + 2'd1;
        if (!found && match[cand]) begin
          found = 1'b1;
          pick  = cand;
        end
      end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        rr_q <= tgt_idx_t'(NB_TARGETS - 1);
      end else if (found && cut_ready[i]) begin
        rr_q <= pick;
      end
    end

    assign cut_in.rdata = tgt_rdata_i[pick];
    assign cut_in.id    = tgt_id_i[pick];

    assign sel_found[i] = found;
    assign sel_idx[i]   = pick;

    bus_spill_reg #(
      .T (rsp_payload_t)
    ) i_rsp_cut (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .valid_i  (found),
      .ready_o  (cut_ready[i]),
      .data_i   (cut_in),
      .valid_o  (rsp_valid_o[i]),
      .ready_i  (rsp_ready_i[i]),
      .data_o   (cut_out)
    );

    // drop the initiator index again
    assign rsp_rdata_o[i] = cut_out.rdata;
    assign rsp_id_o[i]    = cut_out.id[ID_IN_WIDTH-1:0];
  end

  // a target sees ready only from the initiator that picked it
  always_comb begin
    tgt_ready_o = '0;
    for (int t = 0; t < NB_TARGETS; t++) begin
      for (int i = 0; i < NB_INITIATORS; i++) begin
        if (sel_found[i] && sel_idx[i] == tgt_idx_t'(t) && cut_ready[i]) begin
          tgt_ready_o[t] = 1'b1;
        end
      end
    end
  end

endmodule

// ==== source/bus_spill_reg.sv ====
// two-entry cut register
module bus_spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // storage, written at wr_ptr_q and read at rd_ptr_q
  T           mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] cnt_q;
  logic       push;
  logic       pop;

  // both handshake outputs come from registers only
  assign ready_o = (cnt_q != 2'd2);
  assign valid_o = (cnt_q != 2'd0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // simultaneous push and pop leaves the fill level unchanged
      if (push && !pop) begin
        cnt_q <= cnt_q + 2'd1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== source/bus_target_arb.sv ====
// per-target round-robin arbiter
module bus_target_arb (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  // initiator side
  input  logic [cluster_bus_pkg::NB_INITIATORS-1:0]  req_valid_i,
  output logic [cluster_bus_pkg::NB_INITIATORS-1:0]  req_ready_o,
  input  logic [cluster_bus_pkg::NB_INITIATORS-1:0]
               [cluster_bus_pkg::ADDR_WIDTH-1:0]     req_addr_i,
  input  logic [cluster_bus_pkg::NB_INITIATORS-1:0]  req_we_i,
  input  logic [cluster_bus_pkg::NB_INITIATORS-1:0]
               [cluster_bus_pkg::DATA_WIDTH-1:0]     req_wdata_i,
  input  logic [cluster_bus_pkg::NB_INITIATORS-1:0]
               [cluster_bus_pkg::ID_IN_WIDTH-1:0]    req_id_i,
  // target side
  output logic                                       tgt_valid_o,
  input  logic                                       tgt_ready_i,
  output logic [cluster_bus_pkg::ADDR_WIDTH-1:0]     tgt_addr_o,
  output logic                                       tgt_we_o,
  output logic [cluster_bus_pkg::DATA_WIDTH-1:0]     tgt_wdata_o,
  output logic [cluster_bus_pkg::ID_OUT_WIDTH-1:0]   tgt_id_o
);

  import cluster_bus_pkg::*;

  // last winner, the search starts one past it
  logic [INIT_IDX_WIDTH-1:0] rr_q;
  logic [INIT_IDX_WIDTH-1:0] gnt_idx;
  logic                      gnt_found;
  logic                      cut_ready;
  req_payload_t              cut_in;
  req_payload_t              cut_out;

  // index arithmetic wraps because the initiator count is a power of two
  always_comb begin
    logic [INIT_IDX_WIDTH-1:0] cand;
    gnt_found = 1'b0;
    gnt_idx   = rr_q;
    for (int k = 1; k <= NB_INITIATORS; k++) begin
      cand = rr_q + INIT_IDX_WIDTH'(k);
      if (!gnt_found && req_valid_i[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = cand;
      end
    end
  end

  always_comb begin
    cut_in.addr  = req_addr_i[gnt_idx];
    cut_in.we    = req_we_i[gnt_idx];
    cut_in.wdata = req_wdata_i[gnt_idx];
    cut_in.id    = {gnt_idx, req_id_i[gnt_idx]};
  end

  // grant goes to the winner only
  always_comb begin
    req_ready_o = '0;
    if (gnt_found) begin
      req_ready_o[gnt_idx] = cut_ready;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q <= INIT_IDX_WIDTH'(NB_INITIATORS - 1);
    end else if (gnt_found && cut_ready) begin
      rr_q <= gnt_idx;
    end
  end

  bus_spill_reg #(
    .T (req_payload_t)
  ) i_req_cut (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (gnt_found),
    .ready_o  (cut_ready),
    .data_i   (cut_in),
    .valid_o  (tgt_valid_o),
    .ready_i  (tgt_ready_i),
    .data_o   (cut_out)
  );

  assign tgt_addr_o  = cut_out.addr;
  assign tgt_we_o    = cut_out.we;
  assign tgt_wdata_o = cut_out.wdata;
  assign tgt_id_o    = cut_out.id;

endmodule

// ==== source/cluster_bus_pkg.sv ====
// cluster bus definitions
package cluster_bus_pkg;

  // datapath widths
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;

  // port counts
  localparam int unsigned NB_INITIATORS = 4;
  localparam int unsigned NB_TARGETS    = 3;

  // the initiator index is prepended to the id on the way to a target
  localparam int unsigned INIT_IDX_WIDTH = 2;
  localparam int unsigned ID_IN_WIDTH    = 4;
  localparam int unsigned ID_OUT_WIDTH   = INIT_IDX_WIDTH + ID_IN_WIDTH;

  typedef logic [1:0] tgt_idx_t;

  // target port order
  localparam tgt_idx_t TGT_TCDM   = 2'd0;
  localparam tgt_idx_t TGT_PERIPH = 2'd1;
  localparam tgt_idx_t TGT_EXT    = 2'd2;

  // cluster window, base moves by 4 MiB per cluster id
  localparam logic [ADDR_WIDTH-1:0] CLUSTER_BASE  = 32'h1000_0000;
  localparam int unsigned           CLUSTER_SHIFT = 22;

  // offsets inside the window
  localparam logic [ADDR_WIDTH-1:0] TCDM_SIZE     = 32'h0010_0000;
  localparam logic [ADDR_WIDTH-1:0] PERIPH_OFFSET = 32'h0020_0000;
  localparam logic [ADDR_WIDTH-1:0] CLUSTER_SIZE  = 32'h0040_0000;

  // request beat as seen by a target
  typedef struct packed {
    logic [ADDR_WIDTH-1:0]   addr;
    logic                    we;
    logic [DATA_WIDTH-1:0]   wdata;
    logic [ID_OUT_WIDTH-1:0] id;
  } req_payload_t;

  // response beat as returned by a target
  typedef struct packed {
    logic [DATA_WIDTH-1:0]   rdata;
    logic [ID_OUT_WIDTH-1:0] id;
  } rsp_payload_t;

endpackage

// ==== source/cluster_bus_wrap.sv ====
// cluster bus crossbar top
module cluster_bus_wrap (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  input  logic [5:0]                                 cluster_id_i,

  // initiator requests: ext, dma, core data, core instr
  input  logic [cluster_bus_pkg::NB_INITIATORS-1:0]  init_req_valid_i,
  output logic [cluster_bus_pkg::NB_INITIATORS-1:0]  init_req_ready_o,
  input  logic [cluster_bus_pkg::NB_INITIATORS-1:0]
               [cluster_bus_pkg::ADDR_WIDTH-1:0]     init_req_addr_i,
  input  logic [cluster_bus_pkg::NB_INITIATORS-1:0]  init_req_we_i,
  input  logic [cluster_bus_pkg::NB_INITIATORS-1:0]
               [cluster_bus_pkg::DATA_WIDTH-1:0]     init_req_wdata_i,
  input  logic [cluster_bus_pkg::NB_INITIATORS-1:0]
               [cluster_bus_pkg::ID_IN_WIDTH-1:0]    init_req_id_i,

  // initiator responses
  output logic [cluster_bus_pkg::NB_INITIATORS-1:0]  init_rsp_valid_o,
  input  logic [cluster_bus_pkg::NB_INITIATORS-1:0]  init_rsp_ready_i,
  output logic [cluster_bus_pkg::NB_INITIATORS-1:0]
               [cluster_bus_pkg::DATA_WIDTH-1:0]     init_rsp_rdata_o,
  output logic [cluster_bus_pkg::NB_INITIATORS-1:0]
               [cluster_bus_pkg::ID_IN_WIDTH-1:0]    init_rsp_id_o,

  // target requests: tcdm, periph, ext
  output logic [cluster_bus_pkg::NB_TARGETS-1:0]     tgt_req_valid_o,
  input  logic [cluster_bus_pkg::NB_TARGETS-1:0]     tgt_req_ready_i,
  output logic [cluster_bus_pkg::NB_TARGETS-1:0]
               [cluster_bus_pkg::ADDR_WIDTH-1:0]     tgt_req_addr_o,
  output logic [cluster_bus_pkg::NB_TARGETS-1:0]     tgt_req_we_o,
  output logic [cluster_bus_pkg::NB_TARGETS-1:0]
               [cluster_bus_pkg::DATA_WIDTH-1:0]     tgt_req_wdata_o,
  output logic [cluster_bus_pkg::NB_TARGETS-1:0]
               [cluster_bus_pkg::ID_OUT_WIDTH-1:0]   tgt_req_id_o,

  // target responses
  input  logic [cluster_bus_pkg::NB_TARGETS-1:0]     tgt_rsp_valid_i,
  output logic [cluster_bus_pkg::NB_TARGETS-1:0]     tgt_rsp_ready_o,
  input  logic [cluster_bus_pkg::NB_TARGETS-1:0]
               [cluster_bus_pkg::DATA_WIDTH-1:0]     tgt_rsp_rdata_i,
  input  logic [cluster_bus_pkg::NB_TARGETS-1:0]
               [cluster_bus_pkg::ID_OUT_WIDTH-1:0]   tgt_rsp_id_i
);

  import cluster_bus_pkg::*;

  // decoder result per initiator, also observed by the testbench
  tgt_idx_t [NB_INITIATORS-1:0]                     init_tgt_idx;
  logic     [NB_TARGETS-1:0][NB_INITIATORS-1:0]     dec_valid;
  logic     [NB_TARGETS-1:0][NB_INITIATORS-1:0]     arb_ready;

  bus_addr_map i_addr_map (
    .cluster_id_i (cluster_id_i),
    .req_valid_i  (init_req_valid_i),
    .req_addr_i   (init_req_addr_i),
    .req_ready_o  (init_req_ready_o),
    .tgt_idx_o    (init_tgt_idx),
    .tgt_valid_o  (dec_valid),
    .tgt_ready_i  (arb_ready)
  );

  for (genvar t = 0; t < NB_TARGETS; t++) begin : gen_arb
    bus_target_arb i_target_arb (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .req_valid_i (dec_valid[t]),
      .req_ready_o (arb_ready[t]),
      .req_addr_i  (init_req_addr_i),
      .req_we_i    (init_req_we_i),
      .req_wdata_i (init_req_wdata_i),
      .req_id_i    (init_req_id_i),
      .tgt_valid_o (tgt_req_valid_o[t]),
      .tgt_ready_i (tgt_req_ready_i[t]),
      .tgt_addr_o  (tgt_req_addr_o[t]),
      .tgt_we_o    (tgt_req_we_o[t]),
      .tgt_wdata_o (tgt_req_wdata_o[t]),
      .tgt_id_o    (tgt_req_id_o[t])
    );
  end

  bus_resp_route i_resp_route (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .tgt_valid_i (tgt_rsp_valid_i),
    .tgt_ready_o (tgt_rsp_ready_o),
    .tgt_rdata_i (tgt_rsp_rdata_i),
    .tgt_id_i    (tgt_rsp_id_i),
    .rsp_valid_o (init_rsp_valid_o),
    .rsp_ready_i (init_rsp_ready_i),
    .rsp_rdata_o (init_rsp_rdata_o),
    .rsp_id_o    (init_rsp_id_o)
  );

endmodule

// ==== src.f ====
source/cluster_bus_pkg.sv
source/bus_spill_reg.sv
source/bus_addr_map.sv
source/bus_target_arb.sv
source/bus_resp_route.sv
source/cluster_bus_wrap.sv
verification/cluster_bus_properties.sv
verification/cluster_bus_tb.sv

// ==== verification/cluster_bus_properties.sv ====
// cluster bus handshake properties
module cluster_bus_properties (
  input logic                                       clk_i,
  input logic                                       arst_n_i,
  input logic [cluster_bus_pkg::NB_TARGETS-1:0]     tgt_req_valid_o,
  input logic [cluster_bus_pkg::NB_TARGETS-1:0]     tgt_req_ready_i,
  input logic [cluster_bus_pkg::NB_TARGETS-1:0]
              [cluster_bus_pkg::ADDR_WIDTH-1:0]     tgt_req_addr_o,
  input logic [cluster_bus_pkg::NB_TARGETS-1:0]     tgt_req_we_o,
  input logic [cluster_bus_pkg::NB_TARGETS-1:0]
              [cluster_bus_pkg::DATA_WIDTH-1:0]     tgt_req_wdata_o,
  input logic [cluster_bus_pkg::NB_TARGETS-1:0]
              [cluster_bus_pkg::ID_OUT_WIDTH-1:0]   tgt_req_id_o,
  input logic [cluster_bus_pkg::NB_INITIATORS-1:0]  init_rsp_valid_o,
  input logic [cluster_bus_pkg::NB_INITIATORS-1:0]  init_rsp_ready_i,
  input logic [cluster_bus_pkg::NB_INITIATORS-1:0]
              [cluster_bus_pkg::DATA_WIDTH-1:0]     init_rsp_rdata_o,
  input logic [cluster_bus_pkg::NB_INITIATORS-1:0]
              [cluster_bus_pkg::ID_IN_WIDTH-1:0]    init_rsp_id_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import cluster_bus_pkg::*;

  // a stalled request keeps its payload until the target takes it
  for (genvar t = 0; t < NB_TARGETS; t++) begin : gen_tgt
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      tgt_req_valid_o[t] && !tgt_req_ready_i[t] |=> tgt_req_valid_o[t] &&
      $stable({tgt_req_addr_o[t], tgt_req_we_o[t], tgt_req_wdata_o[t], tgt_req_id_o[t]}))
      else $error("target %0d request changed while stalled", t);
  end

  for (genvar i = 0; i < NB_INITIATORS; i++) begin : gen_init
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      init_rsp_valid_o[i] && !init_rsp_ready_i[i] |=> init_rsp_valid_o[i] &&
      $stable({init_rsp_rdata_o[i], init_rsp_id_o[i]}))
      else $error("initiator %0d response changed while stalled", i);
  end

  // nothing leaves the bus while reset is held
  assert property (@(posedge clk_i)
    !arst_n_i |-> (tgt_req_valid_o == '0) && (init_rsp_valid_o == '0))
    else $error("valid raised during reset");

endmodule

bind cluster_bus_wrap cluster_bus_properties i_properties (
  .clk_i            (clk_i),
  .arst_n_i         (arst_n_i),
  .tgt_req_valid_o  (tgt_req_valid_o),
  .tgt_req_ready_i  (tgt_req_ready_i),
  .tgt_req_addr_o   (tgt_req_addr_o),
  .tgt_req_we_o     (tgt_req_we_o),
  .tgt_req_wdata_o  (tgt_req_wdata_o),
  .tgt_req_id_o     (tgt_req_id_o),
  .init_rsp_valid_o (init_rsp_valid_o),
  .init_rsp_ready_i (init_rsp_ready_i),
  .init_rsp_rdata_o (init_rsp_rdata_o),
  .init_rsp_id_o    (init_rsp_id_o)
);

// ==== verification/cluster_bus_tb.sv ====
// cluster bus testbench
module cluster_bus_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import cluster_bus_pkg::*;

  localparam int unsigned PHASES      = 9;
  localparam int unsigned DRAIN_LIMIT = 3000;

  logic clk = 1'b0;
  logic arst_n_i;
  logic [5:0] cluster_id_i;

  logic [NB_INITIATORS-1:0]                   init_req_valid_i;
  logic [NB_INITIATORS-1:0]                   init_req_ready_o;
  logic [NB_INITIATORS-1:0][ADDR_WIDTH-1:0]   init_req_addr_i;
  logic [NB_INITIATORS-1:0]                   init_req_we_i;
  logic [NB_INITIATORS-1:0][DATA_WIDTH-1:0]   init_req_wdata_i;
  logic [NB_INITIATORS-1:0][ID_IN_WIDTH-1:0]  init_req_id_i;
  logic [NB_INITIATORS-1:0]                   init_rsp_valid_o;
  logic [NB_INITIATORS-1:0]                   init_rsp_ready_i;
  logic [NB_INITIATORS-1:0][DATA_WIDTH-1:0]   init_rsp_rdata_o;
  logic [NB_INITIATORS-1:0][ID_IN_WIDTH-1:0]  init_rsp_id_o;
  logic [NB_TARGETS-1:0]                      tgt_req_valid_o;
  logic [NB_TARGETS-1:0]                      tgt_req_ready_i;
  logic [NB_TARGETS-1:0][ADDR_WIDTH-1:0]      tgt_req_addr_o;
  logic [NB_TARGETS-1:0]                      tgt_req_we_o;
  logic [NB_TARGETS-1:0][DATA_WIDTH-1:0]      tgt_req_wdata_o;
  logic [NB_TARGETS-1:0][ID_OUT_WIDTH-1:0]    tgt_req_id_o;
  logic [NB_TARGETS-1:0]                      tgt_rsp_valid_i;
  logic [NB_TARGETS-1:0]                      tgt_rsp_ready_o;
  logic [NB_TARGETS-1:0][DATA_WIDTH-1:0]      tgt_rsp_rdata_i;
  logic [NB_TARGETS-1:0][ID_OUT_WIDTH-1:0]    tgt_rsp_id_i;

  // stimulus and scoreboard state
  logic [31:0]               rng_state = 32'h8b30fb67;
  int unsigned               cycle;
  int unsigned               pend_total;
  int unsigned               launched [NB_INITIATORS];
  int unsigned               quota [NB_INITIATORS];
  logic [ID_IN_WIDTH-1:0]    next_id [NB_INITIATORS];
  logic                      stream_mode;
  tgt_idx_t                  stream_tgt;
  logic                      pend_vld [NB_INITIATORS][16];
  logic [DATA_WIDTH-1:0]     pend_data [NB_INITIATORS][16];
  req_payload_t              exp_q [NB_TARGETS][$];
  rsp_payload_t              rsp_q [NB_TARGETS][$];
  int unsigned               due_q [NB_TARGETS][$];
  logic [INIT_IDX_WIDTH-1:0] grant_hist [$];

  cluster_bus_wrap cluster_bus_wrap_i (
    .clk_i (clk),
    .*
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] window_base(input logic [5:0] cid);
    return CLUSTER_BASE + ({26'd0, cid} << CLUSTER_SHIFT);
  endfunction

  // regions: 0 tcdm, 1 hole, 2 periph, 3 above the window, 4 below it
  function automatic logic [ADDR_WIDTH-1:0] pick_addr(input int unsigned region,
                                                      input logic [5:0] cid);
    logic [ADDR_WIDTH-1:0] base;
    logic [ADDR_WIDTH-1:0] r;
    base = window_base(cid);
    r    = next_rand();
    case (region)
      0:       return base + (r & 32'h000f_fffc);
      1:       return base + TCDM_SIZE + (r & 32'h000f_fffc);
      2:       return base + PERIPH_OFFSET + (r & 32'h001f_fffc);
      3:       return base + CLUSTER_SIZE + (r & 32'h00ff_fffc);
      default: return base - 32'd4 - (r & 32'h00ff_fffc);
    endcase
  endfunction

  function automatic int unsigned region_for(input tgt_idx_t tgt);
    int unsigned pick;
    pick = next_rand() % 3;
    case (tgt)
      TGT_TCDM:   return 0;
      TGT_PERIPH: return 2;
      default:    return (pick == 0) ? 1 : ((pick == 1) ? 3 : 4);
    endcase
  endfunction

  // reference map: tcdm first MiB, periph 2 to 4 MiB, the rest external
  function automatic tgt_idx_t expect_target(input logic [ADDR_WIDTH-1:0] addr,
                                             input logic [5:0] cid);
    logic [ADDR_WIDTH-1:0] base;
    base = window_base(cid);
    if (addr >= base && addr < base + TCDM_SIZE) begin
      return TGT_TCDM;
    end
    if (addr >= base + PERIPH_OFFSET && addr < base + CLUSTER_SIZE) begin
      return TGT_PERIPH;
    end
    return TGT_EXT;
  endfunction

  // each target model scrambles its read data with its own key
  function automatic logic [DATA_WIDTH-1:0] target_key(input tgt_idx_t tgt);
    case (tgt)
      TGT_TCDM:   return 32'h5a5a_0000;
      TGT_PERIPH: return 32'hc3c3_0000;
      default:    return 32'h0f0f_0000;
    endcase
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compare_req(input string name, input req_payload_t act,
                             input req_payload_t exp);
    if (act !== exp) begin
      abort_run($sformatf("** Error: %s got %h expected %h", name, act, exp));
    end
  endtask

  task automatic compare_rsp(input string name, input rsp_payload_t act,
                             input rsp_payload_t exp);
    if (act !== exp) begin
      abort_run($sformatf("** Error: %s got %h expected %h", name, act, exp));
    end
  endtask

  task automatic compare_idx(input string name, input tgt_idx_t act, input tgt_idx_t exp);
    if (act !== exp) begin
      abort_run($sformatf("** Error: %s got %h expected %h", name, act, exp));
    end
  endtask

  task automatic compare_vld(input string name, input logic [NB_TARGETS+NB_INITIATORS-1:0] act,
                             input logic [NB_TARGETS+NB_INITIATORS-1:0] exp);
    if (act !== exp) begin
      abort_run($sformatf("** Error: %s got %h expected %h", name, act, exp));
    end
  endtask

  // all four streaming: the last three grants must all differ from this one
  task automatic check_rotation(input logic [INIT_IDX_WIDTH-1:0] idx);
    foreach (grant_hist[k]) begin
      if (grant_hist[k] == idx) begin
        abort_run($sformatf("initiator %0d granted twice within four grants at target %0d",
                            idx, stream_tgt));
      end
    end
    grant_hist.push_back(idx);
    if (grant_hist.size() > 3) begin
      void'(grant_hist.pop_front());
    end
  endtask

  task automatic collect_responses();
    rsp_payload_t           got;
    rsp_payload_t           want;
    logic [ID_IN_WIDTH-1:0] rid;
    for (int i = 0; i < NB_INITIATORS; i++) begin
      if (init_rsp_valid_o[i] && init_rsp_ready_i[i]) begin
        rid = init_rsp_id_o[i];
        if (!pend_vld[i][rid]) begin
          abort_run($sformatf("initiator %0d got a response to id %h it was not waiting for",
                              i, rid));
        end else begin
          got.rdata  = init_rsp_rdata_o[i];
          got.id     = {INIT_IDX_WIDTH'(i), rid};
          want.rdata = pend_data[i][rid];
          want.id    = {INIT_IDX_WIDTH'(i), rid};
          compare_rsp("init_rsp", got, want);
          pend_vld[i][rid] = 1'b0;
          pend_total--;
        end
      end
      init_rsp_ready_i[i] <= (next_rand() % 3) != 0;
    end
  endtask

  task automatic serve_targets();
    req_payload_t got;
    rsp_payload_t ans;
    for (int t = 0; t < NB_TARGETS; t++) begin
      if (tgt_req_valid_o[t] && tgt_req_ready_i[t]) begin
        got.addr  = tgt_req_addr_o[t];
        got.we    = tgt_req_we_o[t];
        got.wdata = tgt_req_wdata_o[t];
        got.id    = tgt_req_id_o[t];
        if (exp_q[t].size() == 0) begin
          abort_run($sformatf("target %0d received a request that no initiator sent", t));
        end else begin
          compare_req("tgt_req", got, exp_q[t].pop_front());
        end
        if (stream_mode && tgt_idx_t'(t) == stream_tgt) begin
          check_rotation(got.id[ID_OUT_WIDTH-1 -: INIT_IDX_WIDTH]);
        end
        ans.rdata = got.addr ^ target_key(tgt_idx_t'(t));
        ans.id    = got.id;
        rsp_q[t].push_back(ans);
        due_q[t].push_back(cycle + next_rand() % 6);
      end
      tgt_req_ready_i[t] <= (next_rand() % 4) != 0;
      // a held response stays until the router takes it
      if (!tgt_rsp_valid_i[t] || tgt_rsp_ready_o[t]) begin
        if (rsp_q[t].size() > 0 && due_q[t][0] <= cycle) begin
          ans = rsp_q[t].pop_front();
          void'(due_q[t].pop_front());
          tgt_rsp_valid_i[t] <= 1'b1;
          tgt_rsp_rdata_i[t] <= ans.rdata;
          tgt_rsp_id_i[t]    <= ans.id;
        end else begin
          tgt_rsp_valid_i[t] <= 1'b0;
        end
      end
    end
  endtask

  task automatic run_initiators();
    logic [ADDR_WIDTH-1:0]  addr;
    logic [ID_IN_WIDTH-1:0] req_id;
    logic [31:0]            r;
    tgt_idx_t               exp_t;
    int unsigned            region;
    logic                   accepted;
    req_payload_t           exp_req;
    for (int i = 0; i < NB_INITIATORS; i++) begin
      accepted = init_req_valid_i[i] && init_req_ready_o[i];
      if (accepted) begin
        addr   = init_req_addr_i[i];
        req_id = init_req_id_i[i];
        exp_t  = expect_target(addr, cluster_id_i);
        compare_idx("init_tgt_idx", cluster_bus_wrap_i.init_tgt_idx[i], exp_t);
        if (pend_vld[i][req_id]) begin
          abort_run($sformatf("initiator %0d reused id %h while it was pending", i, req_id));
        end
        pend_vld[i][req_id]  = 1'b1;
        pend_data[i][req_id] = addr ^ target_key(exp_t);
        pend_total++;
        exp_req.addr  = addr;
        exp_req.we    = init_req_we_i[i];
        exp_req.wdata = init_req_wdata_i[i];
        exp_req.id    = {INIT_IDX_WIDTH'(i), req_id};
        exp_q[exp_t].push_back(exp_req);
      end
      if (!init_req_valid_i[i] || accepted) begin
        // random phases leave gaps, a stream keeps valid high
        if (launched[i] < quota[i] && (stream_mode || next_rand() % 3 != 0)) begin
          region = stream_mode ? region_for(stream_tgt) : next_rand() % 5;
          r      = next_rand();
          init_req_addr_i[i]  <= pick_addr(region, cluster_id_i);
          init_req_we_i[i]    <= r[7];
          init_req_wdata_i[i] <= next_rand();
          init_req_id_i[i]    <= next_id[i];
          init_req_valid_i[i] <= 1'b1;
          next_id[i] = next_id[i] + 4'd1;
          launched[i]++;
        end else begin
          init_req_valid_i[i] <= 1'b0;
        end
      end
    end
  endtask

  always @(posedge clk) begin
    if (arst_n_i) begin
      cycle++;
      collect_responses();
      serve_targets();
      run_initiators();
    end
  end

  function automatic bit phase_drained();
    for (int i = 0; i < NB_INITIATORS; i++) begin
      if (launched[i] != quota[i]) begin
        return 1'b0;
      end
    end
    return (init_req_valid_i == '0) && (pend_total == 0);
  endfunction

  initial begin
    logic [5:0]  new_cid;
    tgt_idx_t    new_tgt;
    bit          streaming;
    int unsigned wait_cycles;
    arst_n_i         <= 1'b0;
    cluster_id_i     <= '0;
    init_req_valid_i <= '0;
    init_req_addr_i  <= '0;
    init_req_we_i    <= '0;
    init_req_wdata_i <= '0;
    init_req_id_i    <= '0;
    init_rsp_ready_i <= '0;
    tgt_req_ready_i  <= '0;
    tgt_rsp_valid_i  <= '0;
    tgt_rsp_rdata_i  <= '0;
    tgt_rsp_id_i     <= '0;
    cycle            = 0;
    pend_total       = 0;
    stream_mode      <= 1'b0;
    stream_tgt       <= TGT_TCDM;
    for (int i = 0; i < NB_INITIATORS; i++) begin
      launched[i] = 0;
      quota[i]    <= 0;
      next_id[i]  = '0;
      for (int k = 0; k < 16; k++) begin
        pend_vld[i][k] = 1'b0;
      end
    end

    repeat (5) @(posedge clk);
    arst_n_i <= 1'b1;

    // idle bus right after reset
    repeat (3) begin
      @(negedge clk);
      compare_vld("tgt_req_valid_o/init_rsp_valid_o", {tgt_req_valid_o, init_rsp_valid_o}, '0);
    end

    for (int p = 0; p < PHASES; p++) begin
      @(negedge clk);
      new_cid   = 6'(next_rand());
      new_tgt   = tgt_idx_t'(next_rand() % NB_TARGETS);
      streaming = (p % 3 == 2);
      grant_hist.delete();
      @(posedge clk);
      cluster_id_i <= new_cid;
      stream_mode  <= streaming;
      stream_tgt   <= new_tgt;
      for (int i = 0; i < NB_INITIATORS; i++) begin
        quota[i] <= quota[i] + (streaming ? 8 : 12);
      end
      wait_cycles = 0;
      do begin
        @(negedge clk);
        wait_cycles++;
        if (wait_cycles > DRAIN_LIMIT) begin
          abort_run($sformatf("timeout: phase %0d still has %0d requests outstanding",
                              p, pend_total));
        end
      end while (!phase_drained());
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
